// File: hw/l15_msg_pkg.sv
/*
 * L1.5 message definitions
 * Request and return type encodings, access sizes, the wake interrupt code
 * and the packed request and response structs exchanged with the L1.5 cache
 */
package l15_msg_pkg;

    // Default physical address width of the L1.5 request channel
    localparam int L15_ADDR_BITS = 40;

    typedef logic [4:0]               l15_rqtype_t;
    typedef logic [3:0]               l15_rettype_t;
    typedef logic [2:0]               l15_size_t;
    typedef logic [63:0]              l15_word_t;
    typedef logic [L15_ADDR_BITS-1:0] l15_addr_t;

    // Request types sent by the bridge
    localparam l15_rqtype_t RQ_IMISS = 5'b10000;
    localparam l15_rqtype_t RQ_STORE = 5'b00001;

    // Return types seen on the response channel
    localparam l15_rettype_t RET_LOAD   = 4'b0000;
    localparam l15_rettype_t RET_IFILL  = 4'b0001;
    localparam l15_rettype_t RET_ST_ACK = 4'b0100;
    localparam l15_rettype_t RET_INT    = 4'b0111;

    // Access sizes in the PCX encoding
    localparam l15_size_t SZ_1B = 3'b000;
    localparam l15_size_t SZ_2B = 3'b001;
    localparam l15_size_t SZ_4B = 3'b010;

    // Interrupt payload bits 17:16 of word 0 that mark a wake-up
    localparam logic [1:0] WAKE_CODE = 2'b01;

    // Request fields driven towards L1.5, 112 bits
    typedef struct packed {
        l15_rqtype_t rqtype;
        l15_addr_t   address;
        l15_size_t   size;
        l15_word_t   data;
    } l15_req_t;

    // Response from L1.5, 261 bits, word 0 in the low bits of data
    typedef struct packed {
        logic                val;
        l15_rettype_t        rettype;
        l15_word_t [3:0]     data;
    } l15_resp_t;

endpackage

// File: hw/core_port_pkg.sv
/*
 * Core port definitions
 * Address, instruction dword and code line types of the x86 core,
 * the store length encoding and the captured request struct
 */
package core_port_pkg;

    typedef logic [31:0]  core_addr_t;
    typedef logic [31:0]  dword_t;
    typedef logic [127:0] code_line_t;
    typedef logic [2:0]   store_len_t;

    // Store lengths in bytes that the bridge handles
    localparam store_len_t LEN_1B = 3'd1;
    localparam store_len_t LEN_2B = 3'd2;
    localparam store_len_t LEN_4B = 3'd4;

    // One captured core request, 68 bits
    typedef struct packed {
        logic       is_store;
        core_addr_t address;
        dword_t     data;
        store_len_t length;
    } core_req_t;

endpackage

// File: hw/core_request_capture.sv
/*
 * Core request capture
 * Latches instruction fetch and store strobes from the core into one
 * pending request and holds it until the issuer takes it.
 * Strobes are ignored until the first wake-up from the L1.5 side.
 */
`timescale 1ns/1ps

module core_request_capture import core_port_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       readcode_do,
    input  logic       writeburst_do,
    input  core_addr_t readcode_address,
    input  core_addr_t writeburst_address,
    input  dword_t     writeburst_data,
    input  store_len_t writeburst_length,
    input  logic       wake,
    input  logic       take,
    output logic       pending,
    output core_req_t  pending_req
);

    logic woken;
    logic accept;

    // The core may only start work once it has been woken up
    assign accept = woken && (readcode_do || writeburst_do);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            woken   <= 1'b0;
            pending <= 1'b0;
        end else begin
            // Stays set for good after the first wake pulse
            if (wake) begin
                woken <= 1'b1;
            end
            if (take) begin
                pending <= 1'b0;
            end
            // A new strobe wins over a clear in the same cycle
            if (accept) begin
                pending <= 1'b1;
            end
        end
    end

    // Fetch has priority when both strobes come together
    always_ff @(posedge clk) begin
        if (accept) begin
            pending_req.is_store <= !readcode_do;
            pending_req.address  <= readcode_do ? readcode_address : writeburst_address;
            pending_req.data     <= writeburst_data;
            pending_req.length   <= writeburst_length;
        end
    end

endmodule

// File: hw/l15_request_issuer.sv
/*
 * L1.5 request issuer
 * Takes one pending core request at a time, forms the L1.5 request
 * fields and holds val until the header is accepted.
 * It then waits for the matching completion before going idle again.
 */
`timescale 1ns/1ps

module l15_request_issuer import l15_msg_pkg::*, core_port_pkg::*; #(
    parameter int L15_ADDR_WIDTH = 40
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pending,
    input  core_req_t pending_req,
    output logic      take,
    input  logic      header_ack,
    input  logic      fill_ret,
    input  logic      st_ack,
    output logic      fetch_half,
    output l15_req_t  l15_req,
    output logic      l15_val
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_RESP
    } issue_state_t;

    issue_state_t              state;
    logic [L15_ADDR_WIDTH-1:0] req_addr_ext;
    dword_t                    store_swapped;
    logic                      req_done;

    // Map the core store length onto the L1.5 size code
    function automatic l15_size_t len_to_size(input store_len_t len);
        l15_size_t sz;
        case (len)
            LEN_1B:  sz = SZ_1B;
            LEN_2B:  sz = SZ_2B;
            LEN_4B:  sz = SZ_4B;
            default: sz = SZ_4B;
        endcase
        return sz;
    endfunction

    // A fetch asks for the whole 32-byte line, a store for its exact byte
    assign req_addr_ext = L15_ADDR_WIDTH'(pending_req.is_store ? pending_req.address :
                                          {pending_req.address[31:5], 5'd0});

    // L1.5 is big endian so the store bytes are reversed
    assign store_swapped = {<<8{pending_req.data}};

    assign take = (state == IDLE) && pending;

    // Completion event depends on the kind of request in flight
    assign req_done = (l15_req.rqtype == RQ_STORE) ? st_ack : fill_ret;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            l15_val <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        l15_val <= 1'b1;
                        state   <= SEND;
                    end
                end
                // val and the fields stay put until L1.5 accepts the header
                SEND: begin
                    if (header_ack) begin
                        l15_val <= 1'b0;
                        state   <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (req_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields load only when a request is taken
    always_ff @(posedge clk) begin
        if (take) begin
            l15_req.address <= l15_addr_t'(req_addr_ext);
            if (pending_req.is_store) begin
                l15_req.rqtype <= RQ_STORE;
                l15_req.size   <= len_to_size(pending_req.length);
                // Same dword in both halves of the 64-bit word
                l15_req.data   <= {2{store_swapped}};
            end else begin
                l15_req.rqtype <= RQ_IMISS;
                l15_req.size   <= SZ_4B;
                l15_req.data   <= '0;
                // Bit 4 picks which 16 bytes of the line go back to the core
                fetch_half     <= pending_req.address[4];
            end
        end
    end

endmodule

// File: hw/l15_response_decoder.sv
/*
 * L1.5 response decoder
 * Acknowledges every response and sorts valid ones into fill, store
 * acknowledge and wake events, with registered pulses to the core
 */
`timescale 1ns/1ps

module l15_response_decoder import l15_msg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  l15_resp_t l15_resp,
    output logic      req_ack,
    output logic      fill_ret,
    output logic      st_ack,
    output logic      wake,
    output logic      writeburst_done,
    output logic      ao486_int
);

    // Every response is taken in the cycle it shows up
    assign req_ack = l15_resp.val;

    always_comb begin
        fill_ret = 1'b0;
        st_ack   = 1'b0;
        wake     = 1'b0;
        if (l15_resp.val) begin
            case (l15_resp.rettype)
                RET_IFILL:  fill_ret = 1'b1;
                RET_ST_ACK: st_ack   = 1'b1;
                // Only interrupts carrying the wake code start the core
                RET_INT:    wake     = (l15_resp.data[0][17:16] == WAKE_CODE);
                // Load returns have no port here and end with the acknowledge alone
                default:    fill_ret = 1'b0;
            endcase
        end
    end

    // One-cycle pulses to the core
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            writeburst_done <= 1'b0;
            ao486_int       <= 1'b0;
        end else begin
            writeburst_done <= st_ack;
            ao486_int       <= wake;
        end
    end

endmodule

// File: hw/fetch_line_deliver.sv
/*
 * Fetch line delivery
 * Byte-swaps a returned instruction line, keeps the 16-byte half the core
 * asked for and hands it over one dword per cycle, then as a whole
 */
`timescale 1ns/1ps

module fetch_line_deliver import l15_msg_pkg::*, core_port_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fill_ret,
    input  l15_word_t [3:0] fill_data,
    input  logic            fetch_half,
    output dword_t          readcode_partial,
    output logic            readcode_partial_done,
    output code_line_t      readcode_line,
    output logic            request_readcode_done
);

    logic [255:0] swapped_line;
    code_line_t   sel_half;
    logic         active;
    logic [1:0]   dword_cnt;

    // Each 64-bit word arrives big endian, word 0 stays lowest
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            swapped_line[64*w +: 64] = {<<8{fill_data[w]}};
        end
    end

    assign sel_half = fetch_half ? swapped_line[255:128] : swapped_line[127:0];

    // The counter points at the next dword, wrapping to 0 after the last one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active                <= 1'b0;
            dword_cnt             <= 2'd0;
            readcode_partial_done <= 1'b0;
            request_readcode_done <= 1'b0;
        end else begin
            request_readcode_done <= 1'b0;
            if (fill_ret) begin
                active                <= 1'b1;
                dword_cnt             <= 2'd1;
                readcode_partial_done <= 1'b1;
            end else if (active) begin
                dword_cnt <= dword_cnt + 2'd1;
                // Four dwords are out, the full line follows
                if (dword_cnt == 2'd0) begin
                    active                <= 1'b0;
                    readcode_partial_done <= 1'b0;
                    request_readcode_done <= 1'b1;
                end
            end
        end
    end

    // Dword 0 goes straight from the response, the rest from the held line
    always_ff @(posedge clk) begin
        if (fill_ret) begin
            readcode_line    <= sel_half;
            readcode_partial <= sel_half[31:0];
        end else if (active && dword_cnt != 2'd0) begin
            readcode_partial <= readcode_line[dword_cnt*32 +: 32];
        end
    end

endmodule

// File: hw/ao486_l15_transducer.sv
/*
 * ao486 to L1.5 bridge
 * Connects the fetch and store ports of the core to the L1.5 request
 * and response channel, with wake-up handling from the L1.5 side
 */
`timescale 1ns/1ps

module ao486_l15_transducer import l15_msg_pkg::*, core_port_pkg::*; #(
    parameter int L15_ADDR_WIDTH = 40
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       readcode_do,
    input  core_addr_t readcode_address,
    input  logic       writeburst_do,
    input  core_addr_t writeburst_address,
    input  dword_t     writeburst_data,
    input  store_len_t writeburst_length,
    output dword_t     readcode_partial,
    output logic       readcode_partial_done,
    output code_line_t readcode_line,
    output logic       request_readcode_done,
    output logic       writeburst_done,
    output logic       ao486_int,
    output l15_req_t   l15_req,
    output logic       l15_val,
    input  logic       header_ack,
    input  l15_resp_t  l15_resp,
    output logic       req_ack
);

    logic      pending;
    core_req_t pending_req;
    logic      take;
    logic      fill_ret;
    logic      st_ack;
    logic      wake;
    logic      fetch_half;

    core_request_capture capture0 (
        .clk, .rst_n,
        .readcode_do, .writeburst_do,
        .readcode_address, .writeburst_address,
        .writeburst_data, .writeburst_length,
        .wake, .take,
        .pending, .pending_req
    );

    l15_request_issuer #(
        .L15_ADDR_WIDTH(L15_ADDR_WIDTH)
    ) issuer0 (
        .clk, .rst_n,
        .pending, .pending_req, .take,
        .header_ack, .fill_ret, .st_ack,
        .fetch_half, .l15_req, .l15_val
    );

    l15_response_decoder decoder0 (
        .clk, .rst_n,
        .l15_resp, .req_ack,
        .fill_ret, .st_ack, .wake,
        .writeburst_done, .ao486_int
    );

    // Fill words come straight from the response struct
    fetch_line_deliver deliver0 (
        .clk, .rst_n,
        .fill_ret,
        .fill_data(l15_resp.data),
        .fetch_half,
        .readcode_partial, .readcode_partial_done,
        .readcode_line, .request_readcode_done
    );

endmodule

// File: test/transducer_assertions.sv
/*
 * Protocol assertions for the ao486 to L1.5 bridge
 * Bound to the bridge top level, they watch the L1.5 request handshake
 * and the done and interrupt pulses towards the core
 */
`timescale 1ns/1ps

module transducer_assertions import l15_msg_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input l15_req_t l15_req,
    input logic     l15_val,
    input logic     header_ack,
    input logic     readcode_partial_done,
    input logic     request_readcode_done,
    input logic     ao486_int
);

    // A request that waits for its header acknowledge must not move
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val && !header_ack) |=> (l15_val && $stable(l15_req)))
        else $error("l15_val or request fields changed before header_ack");

    // val goes away right after the header is taken
    a_val_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_val && header_ack) |=> !l15_val)
        else $error("l15_val still high after header_ack");

    // Partial dwords and the full line are never signalled together
    a_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(readcode_partial_done && request_readcode_done))
        else $error("partial and line done pulses overlap");

    // The wake interrupt is a single-cycle pulse
    a_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ao486_int |=> !ao486_int)
        else $error("ao486_int longer than one cycle");

endmodule

// File: test/tb_ao486_l15_transducer.sv
/*
 * Testbench for the ao486 to L1.5 bridge
 * Reads operations from a pattern file, drives the core ports and plays
 * the L1.5 side with a randomly delayed header acknowledge.
 * Request fields, fill delivery, store completion and wake-up are checked
 */
`timescale 1ns/1ps

module tb_ao486_l15_transducer import l15_msg_pkg::*, core_port_pkg::*; ();

    localparam int CLK_HALF    = 20;
    localparam int VAL_TIMEOUT = 10;

    logic       clk;
    logic       rst_n;
    logic       readcode_do;
    core_addr_t readcode_address;
    logic       writeburst_do;
    core_addr_t writeburst_address;
    dword_t     writeburst_data;
    store_len_t writeburst_length;
    dword_t     readcode_partial;
    logic       readcode_partial_done;
    code_line_t readcode_line;
    logic       request_readcode_done;
    logic       writeburst_done;
    logic       ao486_int;
    l15_req_t   l15_req;
    logic       l15_val;
    logic       header_ack;
    l15_resp_t  l15_resp;
    logic       req_ack;

    integer     seed = 32'h8cd2;

    ao486_l15_transducer #(
        .L15_ADDR_WIDTH(40)
    ) dut0 (.*);

    bind ao486_l15_transducer transducer_assertions assert0 (
        .clk(clk), .rst_n(rst_n), .l15_req(l15_req), .l15_val(l15_val),
        .header_ack(header_ack), .readcode_partial_done(readcode_partial_done),
        .request_readcode_done(request_readcode_done), .ao486_int(ao486_int)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Registered outputs are settled and new inputs go in 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // One response cycle from the L1.5 side, acknowledged in the same cycle
    task automatic send_response(input l15_rettype_t rettype, input l15_word_t w0,
                                 input l15_word_t w1, input l15_word_t w2,
                                 input l15_word_t w3);
        l15_resp.val     = 1'b1;
        l15_resp.rettype = rettype;
        l15_resp.data[0] = w0;
        l15_resp.data[1] = w1;
        l15_resp.data[2] = w2;
        l15_resp.data[3] = w3;
        #1;
        check_val("req_ack", 128'(req_ack), 128'(1'b1));
        next_cycle();
        l15_resp = '0;
        #1;
        check_val("req_ack", 128'(req_ack), 128'(1'b0));
    endtask

    // Waits for val, holds header_ack back for a random time and checks the fields
    task automatic issue_and_check(input l15_rqtype_t rqtype, input l15_addr_t addr,
                                   input l15_size_t size, input logic check_data,
                                   input l15_word_t data);
        int          waited;
        int unsigned ack_delay;
        int unsigned resp_gap;
        waited = 0;
        while (!l15_val) begin
            if (waited == VAL_TIMEOUT) begin
                abort_run("Timeout: l15_val never rose after a core request");
            end
            next_cycle();
            waited++;
        end
        ack_delay = $unsigned($random(seed)) % 6;
        for (int unsigned i = 0; i <= ack_delay; i++) begin
            check_val("l15_val", 128'(l15_val), 128'(1'b1));
            check_val("l15_req.rqtype", 128'(l15_req.rqtype), 128'(rqtype));
            check_val("l15_req.address", 128'(l15_req.address), 128'(addr));
            check_val("l15_req.size", 128'(l15_req.size), 128'(size));
            if (check_data) begin
                check_val("l15_req.data", 128'(l15_req.data), 128'(data));
            end
            if (i == ack_delay) begin
                header_ack = 1'b1;
            end
            next_cycle();
        end
        header_ack = 1'b0;
        check_val("l15_val", 128'(l15_val), 128'(1'b0));
        // The L1.5 answer comes back after a variable latency
        resp_gap = $unsigned($random(seed)) % 4;
        repeat (resp_gap) next_cycle();
    endtask

    task automatic run_early(input core_addr_t addr, input dword_t data, input store_len_t len);
        writeburst_do      = 1'b1;
        writeburst_address = addr;
        writeburst_data    = data;
        writeburst_length  = len;
        next_cycle();
        writeburst_do = 1'b0;
        // Nothing may reach L1.5 before the core is woken
        repeat (20) begin
            check_val("l15_val", 128'(l15_val), 128'(1'b0));
            next_cycle();
        end
    endtask

    task automatic run_wake(input l15_word_t word0, input logic exp_int);
        send_response(RET_INT, word0, '0, '0, '0);
        check_val("ao486_int", 128'(ao486_int), 128'(exp_int));
        next_cycle();
        check_val("ao486_int", 128'(ao486_int), 128'(1'b0));
    endtask

    task automatic run_store(input core_addr_t addr, input dword_t data, input store_len_t len,
                             input l15_size_t exp_size, input l15_word_t exp_data);
        writeburst_do      = 1'b1;
        writeburst_address = addr;
        writeburst_data    = data;
        writeburst_length  = len;
        next_cycle();
        writeburst_do = 1'b0;
        // Stores go out at their exact byte address
        issue_and_check(RQ_STORE, l15_addr_t'(addr), exp_size, 1'b1, exp_data);
        send_response(RET_ST_ACK, '0, '0, '0, '0);
        check_val("writeburst_done", 128'(writeburst_done), 128'(1'b1));
        next_cycle();
        check_val("writeburst_done", 128'(writeburst_done), 128'(1'b0));
    endtask

    task automatic run_fill(input core_addr_t addr, input l15_word_t w0, input l15_word_t w1,
                            input l15_word_t w2, input l15_word_t w3, input code_line_t exp_line);
        readcode_do      = 1'b1;
        readcode_address = addr;
        next_cycle();
        readcode_do = 1'b0;
        // Fills ask for the whole 32-byte line
        issue_and_check(RQ_IMISS, l15_addr_t'(addr & 32'hffff_ffe0), SZ_4B, 1'b0, '0);
        send_response(RET_IFILL, w0, w1, w2, w3);
        for (int k = 0; k < 4; k++) begin
            check_val("readcode_partial_done", 128'(readcode_partial_done), 128'(1'b1));
            check_val("request_readcode_done", 128'(request_readcode_done), 128'(1'b0));
            check_val("readcode_partial", 128'(readcode_partial), 128'(exp_line[32*k +: 32]));
            next_cycle();
        end
        check_val("readcode_partial_done", 128'(readcode_partial_done), 128'(1'b0));
        check_val("request_readcode_done", 128'(request_readcode_done), 128'(1'b1));
        check_val("readcode_line", 128'(readcode_line), 128'(exp_line));
        next_cycle();
        check_val("request_readcode_done", 128'(request_readcode_done), 128'(1'b0));
    endtask

    task automatic check_field_count(input int got, input int want);
        if (got != want) begin
            abort_run("Malformed operation line in test/transducer_patterns.txt");
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               op_count;
        logic [63:0]      tok;
        logic [8*256-1:0] rest;
        core_addr_t       f_addr;
        dword_t           f_data;
        store_len_t       f_len;
        l15_size_t        f_size;
        logic             f_flag;
        l15_word_t        f_w0;
        l15_word_t        f_w1;
        l15_word_t        f_w2;
        l15_word_t        f_w3;
        dword_t           f_d0;
        dword_t           f_d1;
        dword_t           f_d2;
        dword_t           f_d3;
        rst_n              = 1'b0;
        readcode_do        = 1'b0;
        readcode_address   = '0;
        writeburst_do      = 1'b0;
        writeburst_address = '0;
        writeburst_data    = '0;
        writeburst_length  = '0;
        header_ack         = 1'b0;
        l15_resp           = '0;
        op_count           = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_val("l15_val", 128'(l15_val), 128'(1'b0));
        check_val("readcode_partial_done", 128'(readcode_partial_done), 128'(1'b0));
        check_val("request_readcode_done", 128'(request_readcode_done), 128'(1'b0));
        check_val("writeburst_done", 128'(writeburst_done), 128'(1'b0));
        check_val("ao486_int", 128'(ao486_int), 128'(1'b0));
        fd = $fopen("test/transducer_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/transducer_patterns.txt");
        end
        while (!$feof(fd)) begin
            tok = '0;
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok == 64'("#")) begin
                    n = $fgets(rest, fd);
                end else if (tok == 64'("EARLY")) begin
                    n = $fscanf(fd, "%h %h %h", f_addr, f_data, f_len);
                    check_field_count(n, 3);
                    run_early(f_addr, f_data, f_len);
                    op_count++;
                end else if (tok == 64'("WAKE")) begin
                    n = $fscanf(fd, "%h %h", f_w0, f_flag);
                    check_field_count(n, 2);
                    run_wake(f_w0, f_flag);
                    op_count++;
                end else if (tok == 64'("STORE")) begin
                    n = $fscanf(fd, "%h %h %h %h %h", f_addr, f_data, f_len, f_size, f_w0);
                    check_field_count(n, 5);
                    run_store(f_addr, f_data, f_len, f_size, f_w0);
                    op_count++;
                end else if (tok == 64'("FILL")) begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f_addr, f_w0, f_w1, f_w2,
                                f_w3, f_d0, f_d1, f_d2, f_d3);
                    check_field_count(n, 9);
                    run_fill(f_addr, f_w0, f_w1, f_w2, f_w3, {f_d3, f_d2, f_d1, f_d0});
                    op_count++;
                end else begin
                    abort_run("Unknown operation in test/transducer_patterns.txt");
                end
            end
        end
        $fclose(fd);
        if (op_count == 0) begin
            abort_run("No operations found in test/transducer_patterns.txt");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // Upper bound on the whole run
    initial begin
        #(CLK_HALF * 2 * 5000);
        abort_run("Simulation did not finish within 5000 clock cycles");
    end

endmodule

// File: test/transducer_patterns.txt
# Hex fields: EARLY addr data len | WAKE word0 exp_int | STORE addr data len exp_size exp_data
# FILL addr word0 word1 word2 word3, then exp_dword0..3 on the next line
# Store strobe before the first wake-up, must be dropped
EARLY 00001000 11223344 4
# Interrupts without the wake code, then the real wake-up
WAKE 0000000000020000 0
WAKE 00000000fffe0000 0
WAKE 0000000000010000 1
# Lower half of the line at 0x2000
FILL 00002004 0123456789abcdef 0011223344556677 8899aabbccddeeff deadbeefcafef00d
     67452301 efcdab89 33221100 77665544
# Byte store
STORE 00004001 000000a5 1 0 a5000000a5000000
# Upper half of the line at 0x2020
FILL 0000203f 0123456789abcdef 0011223344556677 8899aabbccddeeff deadbeefcafef00d
     bbaa9988 ffeeddcc efbeadde 0df0feca
# Halfword store
STORE 00004102 0000beef 2 1 efbe0000efbe0000
# A second wake-up while the core is running
WAKE 00000000abcd5555 1
# Word store with the top address bit set
STORE 80004104 12345678 4 2 7856341278563412
# Upper half of the line at 0x3140
FILL 0000315c 1111111122222222 3333333344444444 a0a1a2a3b0b1b2b3 c0c1c2c3d0d1d2d3
     a3a2a1a0 b3b2b1b0 c3c2c1c0 d3d2d1d0
# Lower half of the same line
FILL 00003148 1111111122222222 3333333344444444 a0a1a2a3b0b1b2b3 c0c1c2c3d0d1d2d3
     11111111 22222222 33333333 44444444
# Word store at the top of a page
STORE 0000fffc cafe0042 4 2 4200feca4200feca

// File: ao486_l15_transducer.f
hw/l15_msg_pkg.sv
hw/core_port_pkg.sv
hw/core_request_capture.sv
hw/l15_request_issuer.sv
hw/l15_response_decoder.sv
hw/fetch_line_deliver.sv
hw/ao486_l15_transducer.sv
test/transducer_assertions.sv
test/tb_ao486_l15_transducer.sv

// File: run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --timescale 1ns/1ps -f ao486_l15_transducer.f \
    --top-module tb_ao486_l15_transducer -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
grep -qs "Test completed successfully" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
